/* verilog/rv_pkg.sv */
// widths, special addresses, rv32i opcode and function encodings, core states and bus structs
`default_nettype none

package rv_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int instr_width = 32;
    localparam int num_regs = 32;
    localparam int reg_sel_width = 5;

    // stores to these addresses never reach memory
    localparam logic [addr_width-1:0] out_addr = 32'd1000;
    localparam logic [addr_width-1:0] halt_addr = 32'd1004;
    localparam logic [addr_width-1:0] float_out_addr = 32'd1008;

    localparam logic [6:0] OPIMM = 7'b0010011;
    localparam logic [6:0] LOAD = 7'b0000011;
    localparam logic [6:0] STORE = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] OP = 7'b0110011;
    localparam logic [6:0] LUI = 7'b0110111;
    localparam logic [6:0] AUIPC = 7'b0010111;

    // funct3 alone
    localparam logic [2:0] ADDI = 3'b000;
    localparam logic [2:0] BEQ = 3'b000;
    localparam logic [2:0] BNE = 3'b001;

    // {funct7, funct3} of the OP group, RV32M included
    localparam logic [9:0] ADD = {7'b0000000, 3'b000};
    localparam logic [9:0] SUB = {7'b0100000, 3'b000};
    localparam logic [9:0] SLL = {7'b0000000, 3'b001};
    localparam logic [9:0] SLT = {7'b0000000, 3'b010};
    localparam logic [9:0] SLTU = {7'b0000000, 3'b011};
    localparam logic [9:0] XOR = {7'b0000000, 3'b100};
    localparam logic [9:0] SRL = {7'b0000000, 3'b101};
    localparam logic [9:0] SRA = {7'b0100000, 3'b101};
    localparam logic [9:0] OR = {7'b0000000, 3'b110};
    localparam logic [9:0] AND = {7'b0000000, 3'b111};
    localparam logic [9:0] MUL = {7'b0000001, 3'b000};
    localparam logic [9:0] DIVU = {7'b0000001, 3'b101};
    localparam logic [9:0] REMU = {7'b0000001, 3'b111};

    // C0 fetch, C1 execute, C2 wait for memory or divider
    typedef enum logic [2:0] {
        C0,
        C1,
        C2,
        HALTED
    } e_state;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wr_data;
        logic                  rd;
        logic                  wr;
    } mem_req_t;

    typedef struct packed {
        logic [data_width-1:0] rd_data;
        logic                  ack;
    } mem_rsp_t;

    typedef struct packed {
        logic [data_width-1:0]    a;
        logic [data_width-1:0]    b;
        logic [reg_sel_width-1:0] quot_sel;
        logic [reg_sel_width-1:0] rem_sel;
    } div_req_t;

    typedef struct packed {
        logic [reg_sel_width-1:0] sel;
        logic [data_width-1:0]    data;
        logic                     req;
    } rf_wr_t;

endpackage

`default_nettype wire

/* verilog/int_div_regfile.sv */
// iterative restoring unsigned divider with quotient and remainder register write-back
`default_nettype none

module int_div_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  rv_pkg::div_req_t   div_in,
    input  logic               rf_wr_ack,
    output logic               busy,
    output rv_pkg::rf_wr_t     rf_wr
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_RUN,
        D_QUOT,
        D_REM
    } div_state_t;

    localparam int cnt_width = $clog2(data_width);

    div_state_t state;
    logic [cnt_width-1:0] cnt;
    logic [data_width-1:0] quot;
    logic [data_width-1:0] rem;
    logic [data_width-1:0] divisor;
    logic [reg_sel_width-1:0] quot_sel;
    logic [reg_sel_width-1:0] rem_sel;
    logic [data_width:0] rem_shift;
    logic [data_width:0] diff;

    // first write-back step, a zero select skips its write
    function automatic div_state_t wb_start(input logic [reg_sel_width-1:0] q_sel,
                                            input logic [reg_sel_width-1:0] r_sel);
        if (q_sel != '0) begin
            return D_QUOT;
        end
        return (r_sel != '0) ? D_REM : D_IDLE;
    endfunction

    // one restoring step, bring in the next dividend bit and try the subtract
    assign rem_shift = {rem, quot[data_width-1]};
    assign diff = rem_shift - {1'b0, divisor};

    assign busy = (state != D_IDLE);
    assign rf_wr.req = (state == D_QUOT) || (state == D_REM);
    assign rf_wr.sel = (state == D_REM) ? rem_sel : quot_sel;
    assign rf_wr.data = (state == D_REM) ? rem : quot;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= D_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (req) begin
                        cnt <= cnt_width'(data_width - 1);
                        // zero divisor goes straight to write-back
                        state <= (div_in.b == '0) ? wb_start(div_in.quot_sel, div_in.rem_sel)
                                                  : D_RUN;
                    end
                end
                D_RUN: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= wb_start(quot_sel, rem_sel);
                    end
                end
                D_QUOT: begin
                    if (rf_wr_ack) begin
                        state <= (rem_sel != '0) ? D_REM : D_IDLE;
                    end
                end
                D_REM: begin
                    if (rf_wr_ack) begin
                        state <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && req) begin
            quot_sel <= div_in.quot_sel;
            rem_sel <= div_in.rem_sel;
            divisor <= div_in.b;
            if (div_in.b == '0) begin
                // riscv rule: all ones quotient, dividend as remainder
                quot <= '1;
                rem <= div_in.a;
            end else begin
                quot <= div_in.a;
                rem <= '0;
            end
        end else if (state == D_RUN) begin
            if (!diff[data_width]) begin
                rem <= diff[data_width-1:0];
                quot <= {quot[data_width-2:0], 1'b1};
            end else begin
                rem <= rem_shift[data_width-1:0];
                quot <= {quot[data_width-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_ram.sv */
// word memory with fixed reply latency and a load port for the testbench
`default_nettype none

module mem_ram #(
    parameter int mem_latency = 1,
    parameter int mem_words = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  rv_pkg::mem_req_t              req,
    input  logic                          load_en,
    input  logic [rv_pkg::addr_width-1:0] load_addr,
    input  logic [rv_pkg::data_width-1:0] load_data,
    output rv_pkg::mem_rsp_t              rsp
);
    import rv_pkg::*;

    localparam int idx_width = $clog2(mem_words);
    localparam int lat_width = $clog2(mem_latency + 1);

    logic [data_width-1:0] mem [mem_words];
    logic [idx_width-1:0] req_idx;
    logic [idx_width-1:0] load_idx;
    logic [data_width-1:0] rd_data;
    logic [lat_width-1:0] lat_cnt;
    logic pending;
    logic ack;

    // byte address to word index
    assign req_idx = req.addr[idx_width+1:2];
    assign load_idx = load_addr[idx_width+1:2];

    assign rsp.rd_data = rd_data;
    assign rsp.ack = ack;

    // reads and writes act when the request is captured, only the ack is delayed
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (req.wr) begin
            mem[req_idx] <= req.wr_data;
        end
        if (req.rd) begin
            rd_data <= mem[req_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            lat_cnt <= '0;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (req.rd || req.wr) begin
                pending <= 1'b1;
                lat_cnt <= '0;
            end else if (pending) begin
                if (lat_cnt == lat_width'(mem_latency - 1)) begin
                    pending <= 1'b0;
                    ack <= 1'b1;
                end else begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/proc.sv */
// multi-cycle rv32i core: decode, register file, alu, fetch/execute/wait fsm and output strobes
`default_nettype none

module proc (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  rv_pkg::mem_rsp_t              mem_rsp,
    output rv_pkg::mem_req_t              mem_req,
    output logic [rv_pkg::data_width-1:0] out,
    output logic                          out_en,
    output logic                          out_fl_en,
    output logic                          halt,
    output logic [rv_pkg::data_width-1:0] x1,
    output logic [rv_pkg::addr_width-1:0] pc
);
    import rv_pkg::*;

    e_state state;
    e_state next_state;
    logic [addr_width-1:0] next_pc;
    logic [addr_width-1:0] fetch_pc;
    logic fetch;

    logic [data_width-1:0] regs [num_regs];
    rf_wr_t wr;

    // fetched word, only meaningful in the ack cycle of a fetch
    logic [instr_width-1:0] instr;
    logic [6:0] op;
    logic [2:0] funct3;
    logic [9:0] op_funct;
    logic [reg_sel_width-1:0] rd_sel;
    logic [reg_sel_width-1:0] rs1_sel;
    logic [reg_sel_width-1:0] rs2_sel;
    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [data_width-1:0] i_imm;
    logic [data_width-1:0] s_imm;
    logic [data_width-1:0] b_imm;
    logic [data_width-1:0] u_imm;
    logic [addr_width-1:0] ld_addr;
    logic [addr_width-1:0] st_addr;
    logic [data_width-1:0] alu_res;
    logic alu_hit;

    // instruction kept for the wait phase
    logic [instr_width-1:0] c2_instr;
    logic [6:0] c2_op;
    logic [reg_sel_width-1:0] c2_rd_sel;

    logic div_req;
    div_req_t div_in;
    logic div_busy;
    rf_wr_t div_wr;
    logic div_ack;

    int_div_regfile i_int_div_regfile (
        .clk(clk),
        .rst(rst),
        .req(div_req),
        .div_in(div_in),
        .rf_wr_ack(div_ack),
        .busy(div_busy),
        .rf_wr(div_wr)
    );

    assign instr = mem_rsp.rd_data;
    assign op = instr[6:0];
    assign funct3 = instr[14:12];
    assign op_funct = {instr[31:25], instr[14:12]};
    assign rd_sel = instr[11:7];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    // x0 reads as zero, it is never written
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign ld_addr = rs1_data + i_imm;
    assign st_addr = rs1_data + s_imm;

    assign c2_op = c2_instr[6:0];
    assign c2_rd_sel = c2_instr[11:7];

    assign x1 = regs[1];
    // store data, qualified by the strobes
    assign out = rs2_data;
    assign next_pc = fetch ? fetch_pc : pc;

    always_comb begin
        alu_res = '0;
        alu_hit = 1'b1;
        case (op_funct)
            ADD: alu_res = rs1_data + rs2_data;
            SUB: alu_res = rs1_data - rs2_data;
            SLT: alu_res = {{(data_width-1){1'b0}}, $signed(rs1_data) < $signed(rs2_data)};
            SLTU: alu_res = {{(data_width-1){1'b0}}, rs1_data < rs2_data};
            AND: alu_res = rs1_data & rs2_data;
            OR: alu_res = rs1_data | rs2_data;
            XOR: alu_res = rs1_data ^ rs2_data;
            SLL: alu_res = rs1_data << rs2_data[4:0];
            SRL: alu_res = rs1_data >> rs2_data[4:0];
            SRA: alu_res = $unsigned($signed(rs1_data) >>> rs2_data[4:0]);
            MUL: alu_res = rs1_data * rs2_data;
            default: alu_hit = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        fetch = 1'b0;
        fetch_pc = pc + 32'd4;
        mem_req = '0;
        wr = '0;
        div_req = 1'b0;
        div_in = '0;
        div_ack = 1'b0;
        out_en = 1'b0;
        out_fl_en = 1'b0;
        halt = (state == HALTED);
        case (state)
            C0: begin
                if (start) begin
                    fetch = 1'b1;
                    fetch_pc = pc;
                end
            end
            C1: begin
                // single-cycle instructions also launch the next fetch here
                if (mem_rsp.ack) begin
                    fetch = 1'b1;
                    case (op)
                        OPIMM: begin
                            if (funct3 == ADDI) begin
                                wr = '{sel: rd_sel, data: rs1_data + i_imm, req: 1'b1};
                            end
                        end
                        OP: begin
                            if (op_funct == DIVU || op_funct == REMU) begin
                                // a divide into x0 is a no-op and skips the divider
                                if (rd_sel != '0) begin
                                    fetch = 1'b0;
                                    // divider is idle here, the core waits for its last write
                                    div_req = !div_busy;
                                    div_in.a = rs1_data;
                                    div_in.b = rs2_data;
                                    div_in.quot_sel = (op_funct == DIVU) ? rd_sel : '0;
                                    div_in.rem_sel = (op_funct == REMU) ? rd_sel : '0;
                                    next_state = C2;
                                end
                            end else if (alu_hit) begin
                                wr = '{sel: rd_sel, data: alu_res, req: 1'b1};
                            end
                        end
                        LUI: wr = '{sel: rd_sel, data: u_imm, req: 1'b1};
                        AUIPC: wr = '{sel: rd_sel, data: pc + u_imm, req: 1'b1};
                        BRANCH: begin
                            if ((funct3 == BEQ && rs1_data == rs2_data) ||
                                (funct3 == BNE && rs1_data != rs2_data)) begin
                                fetch_pc = pc + b_imm;
                            end
                        end
                        LOAD: begin
                            fetch = 1'b0;
                            mem_req.addr = ld_addr;
                            mem_req.rd = 1'b1;
                            next_state = C2;
                        end
                        STORE: begin
                            case (st_addr)
                                out_addr: out_en = 1'b1;
                                float_out_addr: out_fl_en = 1'b1;
                                halt_addr: begin
                                    fetch = 1'b0;
                                    halt = 1'b1;
                                    next_state = HALTED;
                                end
                                default: begin
                                    fetch = 1'b0;
                                    mem_req.addr = st_addr;
                                    mem_req.wr_data = rs2_data;
                                    mem_req.wr = 1'b1;
                                    next_state = C2;
                                end
                            endcase
                        end
                        default: begin
                            // unknown opcode, stop for good
                            fetch = 1'b0;
                            halt = 1'b1;
                            next_state = HALTED;
                        end
                    endcase
                end
            end
            C2: begin
                case (c2_op)
                    LOAD: begin
                        if (mem_rsp.ack) begin
                            wr = '{sel: c2_rd_sel, data: mem_rsp.rd_data, req: 1'b1};
                            fetch = 1'b1;
                        end
                    end
                    STORE: fetch = mem_rsp.ack;
                    default: begin
                        // divider write-back, only one write per instruction
                        if (div_wr.req) begin
                            div_ack = 1'b1;
                            wr = div_wr;
                            fetch = 1'b1;
                        end
                    end
                endcase
            end
            default: ;
        endcase
        if (fetch) begin
            next_state = C1;
            mem_req.addr = fetch_pc;
            mem_req.rd = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C0;
            pc <= '0;
        end else begin
            state <= next_state;
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == C1 && mem_rsp.ack) begin
            c2_instr <= instr;
        end
    end

    // single write port, x0 stays zero
    always_ff @(posedge clk) begin
        if (wr.req && wr.sel != '0) begin
            regs[wr.sel] <= wr.data;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_top.sv */
// top level: rv32i core connected to its word memory
`default_nettype none

module rv_top #(
    parameter int mem_latency = 1,
    parameter int mem_words = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          load_en,
    input  logic [rv_pkg::addr_width-1:0] load_addr,
    input  logic [rv_pkg::data_width-1:0] load_data,
    output logic [rv_pkg::data_width-1:0] out,
    output logic                          out_en,
    output logic                          out_fl_en,
    output logic                          halt,
    output logic [rv_pkg::data_width-1:0] x1,
    output logic [rv_pkg::addr_width-1:0] pc
);
    import rv_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    proc i_proc (
        .clk(clk),
        .rst(rst),
        .start(start),
        .mem_rsp(mem_rsp),
        .mem_req(mem_req),
        .out(out),
        .out_en(out_en),
        .out_fl_en(out_fl_en),
        .halt(halt),
        .x1(x1),
        .pc(pc)
    );

    mem_ram #(
        .mem_latency(mem_latency),
        .mem_words(mem_words)
    ) i_mem_ram (
        .clk(clk),
        .rst(rst),
        .req(mem_req),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .rsp(mem_rsp)
    );

endmodule

`default_nettype wire

/* test/tb_chk.sv */
// bound assertions on the core: bus and strobe exclusivity, held halt, quiet bus when halted
`default_nettype none

module tb_chk (
    input logic clk,
    input logic rst,
    input logic mem_rd,
    input logic mem_wr,
    input logic out_en,
    input logic out_fl_en,
    input logic halt
);

    int assert_errors = 0;

    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else begin
            $error("memory read and write requested together");
            assert_errors++;
        end

    a_strobe_excl: assert property (@(posedge clk) disable iff (rst) !(out_en && out_fl_en))
        else begin
            $error("integer and float strobes high together");
            assert_errors++;
        end

    // halt is a level that only reset clears
    a_halt_held: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else begin
            $error("halt fell without reset");
            assert_errors++;
        end

    a_no_req_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !(mem_rd || mem_wr))
        else begin
            $error("memory request while halted");
            assert_errors++;
        end

endmodule

`default_nettype wire

/* test/tb_monitor.sv */
// monitor: compares output strobes, halt, final x1 and halt pc against the expected values
`default_nettype none

module tb_monitor #(
    parameter int max_exp = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [rv_pkg::data_width-1:0] out,
    input  logic                          out_en,
    input  logic                          out_fl_en,
    input  logic                          halt,
    input  logic [rv_pkg::data_width-1:0] x1,
    input  logic [rv_pkg::addr_width-1:0] pc,
    input  logic [rv_pkg::data_width:0]   exp_list [max_exp],
    input  int                            exp_count,
    input  logic [rv_pkg::data_width-1:0] exp_x1,
    input  logic [rv_pkg::addr_width-1:0] exp_pc,
    output int                            value_errors,
    output int                            other_errors,
    output logic                          done
);
    import rv_pkg::*;

    localparam int start_timeout = 2000;
    localparam int halt_timeout = 10000;
    localparam int quiet_cycles = 20;

    int seen;

    task automatic sample_strobes(input logic after_halt);
        logic is_fl;
        if (!(out_en || out_fl_en)) begin
            return;
        end
        is_fl = out_fl_en;
        if (after_halt) begin
            other_errors++;
            $display("output strobe at %0t after halt", $time);
        end else if (seen >= exp_count) begin
            other_errors++;
            $display("more output strobes than expected, extra value %h at %0t", out, $time);
        end else begin
            if (exp_list[seen][data_width] != is_fl) begin
                value_errors++;
                $display("Fail %0t: strobe %0d float flag %0b, expected %0b",
                         $time, seen, is_fl, exp_list[seen][data_width]);
            end
            if (out !== exp_list[seen][data_width-1:0]) begin
                value_errors++;
                $display("Fail %0t: strobe %0d value %h, expected %h",
                         $time, seen, out, exp_list[seen][data_width-1:0]);
            end
            seen++;
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    initial begin
        int cycles;
        logic halt_seen;
        value_errors = 0;
        other_errors = 0;
        done = 1'b0;
        seen = 0;
        halt_seen = 1'b0;
        cycles = 0;
        while (!start && cycles < start_timeout) begin
            @(negedge clk);
            cycles++;
        end
        cycles = 0;
        while (start && !halt_seen && cycles < halt_timeout) begin
            @(negedge clk);
            if (!rst) begin
                sample_strobes(1'b0);
                halt_seen = halt;
            end
            cycles++;
        end
        if (!start) begin
            other_errors++;
            $display("timeout: start did not rise within %0d cycles", start_timeout);
        end else if (!halt_seen) begin
            other_errors++;
            $display("timeout: the core did not halt after start");
        end else begin
            if (seen != exp_count) begin
                other_errors++;
                $display("saw %0d output strobes, expected %0d", seen, exp_count);
            end
            if (x1 !== exp_x1) begin
                value_errors++;
                $display("Fail %0t: x1 is %h after halt, expected %h", $time, x1, exp_x1);
            end
            if (pc !== exp_pc) begin
                value_errors++;
                $display("Fail %0t: pc is %h after halt, expected %h", $time, pc, exp_pc);
            end
            repeat (quiet_cycles) begin
                @(negedge clk);
                sample_strobes(1'b1);
                if (!halt) begin
                    other_errors++;
                    $display("halt dropped at %0t", $time);
                end
            end
        end
        done = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_top.sv */
// testbench top: clock, reset, program load from the input file, DUT, monitor and bound checker
`default_nettype none

module tb_top;
    import rv_pkg::*;

    localparam int mem_latency = 2;
    localparam int mem_words = 256;
    localparam int max_exp = 64;
    localparam int done_timeout = 20000;

    logic clk;
    logic rst;
    logic start;
    logic load_en;
    logic [addr_width-1:0] load_addr;
    logic [data_width-1:0] load_data;
    logic [data_width-1:0] out;
    logic out_en;
    logic out_fl_en;
    logic halt;
    logic [data_width-1:0] x1;
    logic [addr_width-1:0] pc;

    logic [data_width-1:0] prog [$];
    // top bit marks a float strobe
    logic [data_width:0] exp_list [max_exp];
    int exp_count;
    logic [data_width-1:0] exp_x1;
    logic [addr_width-1:0] exp_pc;
    int tb_errors;
    int value_errors;
    int other_errors;
    logic done;

    rv_top #(
        .mem_latency(mem_latency),
        .mem_words(mem_words)
    ) i_rv_top (
        .clk(clk),
        .rst(rst),
        .start(start),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .out(out),
        .out_en(out_en),
        .out_fl_en(out_fl_en),
        .halt(halt),
        .x1(x1),
        .pc(pc)
    );

    tb_monitor #(
        .max_exp(max_exp)
    ) i_tb_monitor (
        .clk(clk),
        .rst(rst),
        .start(start),
        .out(out),
        .out_en(out_en),
        .out_fl_en(out_fl_en),
        .halt(halt),
        .x1(x1),
        .pc(pc),
        .exp_list(exp_list),
        .exp_count(exp_count),
        .exp_x1(exp_x1),
        .exp_pc(exp_pc),
        .value_errors(value_errors),
        .other_errors(other_errors),
        .done(done)
    );

    bind proc tb_chk i_tb_chk (
        .clk(clk),
        .rst(rst),
        .mem_rd(mem_req.rd),
        .mem_wr(mem_req.wr),
        .out_en(out_en),
        .out_fl_en(out_fl_en),
        .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // lines: p word, e flag value, x final x1
    task automatic read_input();
        int fd;
        int n;
        string line;
        logic [data_width-1:0] v1;
        logic [data_width-1:0] v2;
        fd = $fopen("test/tb_input.txt", "r");
        if (fd == 0) begin
            $display("could not open test/tb_input.txt");
            tb_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            case (line.getc(0))
                "p": begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h", v1);
                    prog.push_back(v1);
                end
                "e": begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", v1, v2);
                    if (n == 2 && exp_count < max_exp) begin
                        exp_list[exp_count] = {v1[0], v2};
                        exp_count++;
                    end else begin
                        n = 0;
                    end
                end
                "x": begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h", exp_x1);
                end
                default: n = 0;
            endcase
            if (n == 0) begin
                $display("bad line in test/tb_input.txt: %s", line);
                tb_errors++;
            end
        end
        $fclose(fd);
        if (prog.size() == 0 || prog.size() > mem_words) begin
            $display("the input file holds %0d program words", prog.size());
            tb_errors++;
        end
    endtask

    // the core stops at the sw x0 to the halt address, pc stays on it
    function automatic logic [addr_width-1:0] halt_store_addr();
        logic [data_width-1:0] w;
        logic [data_width-1:0] imm;
        foreach (prog[i]) begin
            w = prog[i];
            imm = {{20{w[31]}}, w[31:25], w[11:7]};
            if (w[6:0] == STORE && w[19:15] == '0 && imm == halt_addr) begin
                return addr_width'(i * 4);
            end
        end
        return '0;
    endfunction

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_addr <= addr_width'(i * 4);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < done_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: the monitor did not finish within %0d cycles", done_timeout);
            tb_errors++;
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = i_rv_top.i_proc.i_tb_chk.assert_errors;
        $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors + tb_errors, asserts);
        if (value_errors + other_errors + tb_errors + asserts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        exp_count = 0;
        exp_x1 = '0;
        exp_pc = '0;
        tb_errors = 0;
        read_input();
        if (tb_errors == 0) begin
            exp_pc = halt_store_addr();
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            load_program();
            @(posedge clk);
            start <= 1'b1;
            wait_done();
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* test/tb_input.txt */
# p <word>: program word in hex, loaded from address 0 upward, text after it is ignored
# e <flag> <value>: expected strobe, flag 0 integer and 1 float; x <value>: final x1
p 06400293 addi x5, x0, 100
p 3E502423 sw x5, 1000(x0)
p 12345337 lui x6, 0x12345
p 3E602423 sw x6, 1000(x0)
p 00001397 auipc x7, 1
p 3E702423 sw x7, 1000(x0)
p FF900413 addi x8, x0, -7
p 008284B3 add x9, x5, x8
p 3E902423 sw x9, 1000(x0)
p 40540533 sub x10, x8, x5
p 3EA02423 sw x10, 1000(x0)
p 0082F5B3 and x11, x5, x8
p 3EB02423 sw x11, 1000(x0)
p 00536633 or x12, x6, x5
p 3EC02423 sw x12, 1000(x0)
p 0082C6B3 xor x13, x5, x8
p 3ED02423 sw x13, 1000(x0)
p 00400713 addi x14, x0, 4
p 00E297B3 sll x15, x5, x14
p 3EF02423 sw x15, 1000(x0)
p 00E45833 srl x16, x8, x14
p 3F002423 sw x16, 1000(x0)
p 025408B3 mul x17, x8, x5
p 3F102423 sw x17, 1000(x0)
p 00542933 slt x18, x8, x5
p 3F202423 sw x18, 1000(x0)
p 005439B3 sltu x19, x8, x5
p 3F302423 sw x19, 1000(x0)
p 40E45A33 sra x20, x8, x14
p 3F402423 sw x20, 1000(x0)
p 20000A93 addi x21, x0, 512
p 00CAA023 sw x12, 0(x21)
p 000AAB03 lw x22, 0(x21)
p 3F602423 sw x22, 1000(x0)
p 00700B93 addi x23, x0, 7
p 0372DC33 divu x24, x5, x23
p 3F802423 sw x24, 1000(x0)
p 0372FCB3 remu x25, x5, x23
p 3F902423 sw x25, 1000(x0)
p 0202DD33 divu x26, x5, x0
p 3FA02423 sw x26, 1000(x0)
p 0202FDB3 remu x27, x5, x0
p 3FB02423 sw x27, 1000(x0)
p 00300093 addi x1, x0, 3
p 3E102423 loop: sw x1, 1000(x0)
p FFF08093 addi x1, x1, -1
p FE009CE3 bne x1, x0, loop
p 00008463 beq x1, x0, +8 taken
p 3E502423 sw x5, 1000(x0) skipped
p 00028463 beq x5, x0, +8 not taken
p 3E902823 sw x9, 1008(x0)
p 02A00093 addi x1, x0, 42
p 3E002623 sw x0, 1004(x0) halt
p 3E502423 sw x5, 1000(x0) never runs
e 0 00000064
e 0 12345000
e 0 00001010
e 0 0000005D
e 0 FFFFFF95
e 0 00000060
e 0 12345064
e 0 FFFFFF9D
e 0 00000640
e 0 0FFFFFFF
e 0 FFFFFD44
e 0 00000001
e 0 00000000
e 0 FFFFFFFF
e 0 12345064
e 0 0000000E
e 0 00000002
e 0 FFFFFFFF
e 0 00000064
e 0 00000003
e 0 00000002
e 0 00000001
e 1 0000005D
x 0000002A

/* tb.f */
verilog/rv_pkg.sv
verilog/int_div_regfile.sv
verilog/mem_ram.sv
verilog/proc.sv
verilog/rv_top.sv
test/tb_chk.sv
test/tb_monitor.sv
test/tb_top.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_top

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_top --Mdir obj_dir -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "^PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
